//--- sd_cmd_host.f
src/sd_cmd_pkg.sv
src/sd_crc7.sv
src/sd_clk_div.sv
src/sd_cmd_tx.sv
src/sd_cmd_rx.sv
src/cmd_path_ctrl.sv
src/sd_cmd_host.sv
tests/sd_card_responder.sv
tests/tb_sd_cmd_host.sv

//--- Makefile
# Verilator build and run of the SD command path testbench

VERILATOR ?= verilator
TOP       ?= tb_sd_cmd_host
RTL_TOP   ?= sd_cmd_host
FILELIST  ?= sd_cmd_host.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Run failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tests/tb_sd_cmd_host.sv
`timescale 1ns/1ps

module tb_sd_cmd_host;
    import sd_cmd_pkg::*;

    localparam int MAX_CYCLES = 6 * (48 + 64 + 48 + 20) * 4 * 2;

    logic        clk;
    logic        rst_n;
    logic        cmd_valid;
    logic        cmd_ready;
    logic [5:0]  cmd_index;
    logic [31:0] cmd_arg;
    logic [1:0]  resp_type;
    logic        index_check_en;
    logic        crc_check_en;
    logic        resp_valid;
    logic        resp_ready;
    resp48_u     resp_data;
    logic        timeout_err;
    logic        crc_err;
    logic        index_err;
    logic        sd_clk;
    logic        cmd_o;
    logic        cmd_oe;
    logic        cmd_i;

    // Card programming and what it decoded
    logic        resp_en;
    logic [7:0]  resp_gap;
    logic [47:0] resp_word;
    logic        crc_fill;
    logic        crc_corrupt;
    logic        frm_start;
    logic        frm_dir;
    logic [5:0]  frm_index;
    logic [31:0] frm_arg;
    logic        frm_crc_ok;
    logic        frm_end;
    logic [31:0] frm_count;
    logic [47:0] sent_word;

    resp48_u     got_data;
    logic        got_tmo;
    logic        got_crc;
    logic        got_idx;
    string       test_name;
    int          seed = 20209;
    int          test_errors;
    int          passed;
    int          failed;
    int          cycles;

    sd_cmd_host #(.CLK_DIV(4), .RESP_TIMEOUT(64)) i_sd_cmd_host (.*);

    sd_card_responder i_card (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s: %s expected %b actual %b", test_name, what, exp, act);
            test_errors = test_errors + 1;
        end
    endtask

    task automatic check_field6(input string what, input logic [5:0] exp, input logic [5:0] act);
        if (act !== exp) begin
            $display("FAIL %s: %s expected %h actual %h", test_name, what, exp, act);
            test_errors = test_errors + 1;
        end
    endtask

    task automatic check_field32(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (act !== exp) begin
            $display("FAIL %s: %s expected %h actual %h", test_name, what, exp, act);
            test_errors = test_errors + 1;
        end
    endtask

    task automatic check_resp(input string what, input resp48_u exp, input resp48_u act);
        if (act !== exp) begin
            $display("FAIL %s: %s expected %h actual %h", test_name, what, exp, act);
            test_errors = test_errors + 1;
        end
    endtask

    task automatic check_errs(input logic tmo, input logic crc, input logic idx);
        check_flag("timeout_err", tmo, got_tmo);
        check_flag("crc_err", crc, got_crc);
        check_flag("index_err", idx, got_idx);
    endtask

    task automatic open_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic close_test();
        if (test_errors == 0) begin
            $display("PASS %s", test_name);
            passed = passed + 1;
        end else begin
            $display("FAIL %s with %0d wrong values", test_name, test_errors);
            failed = failed + 1;
        end
    endtask

    // Short response with ones in the crc field
    function automatic logic [47:0] make_word(input logic [5:0] idx, input logic [31:0] body);
        return {2'b00, idx, body, 7'h7f, 1'b1};
    endfunction

    task automatic program_card(input logic en, input logic [7:0] gap, input logic [47:0] word,
                                input logic fill, input logic corrupt);
        resp_en     = en;
        resp_gap    = gap;
        resp_word   = word;
        crc_fill    = fill;
        crc_corrupt = corrupt;
    endtask

    task automatic drive_request(input logic [5:0] idx, input logic [31:0] arg,
                                 input logic [1:0] rtype, input logic ichk, input logic cchk);
        cmd_valid      = 1'b1;
        cmd_index      = idx;
        cmd_arg        = arg;
        resp_type      = rtype;
        index_check_en = ichk;
        crc_check_en   = cchk;
    endtask

    task automatic wait_accept();
        while (cmd_ready !== 1'b1) begin
            @(posedge clk);
            #2;
        end
        @(posedge clk);  // Transfer edge
        #2;
        cmd_valid = 1'b0;
    endtask

    task automatic issue_cmd(input logic [5:0] idx, input logic [31:0] arg,
                             input logic [1:0] rtype, input logic ichk, input logic cchk);
        drive_request(idx, arg, rtype, ichk, cchk);
        wait_accept();
    endtask

    task automatic wait_result();
        while (resp_valid !== 1'b1) begin
            @(posedge clk);
            #2;
        end
        got_data = resp_data;
        got_tmo  = timeout_err;
        got_crc  = crc_err;
        got_idx  = index_err;
        if (resp_ready) begin
            @(posedge clk);  // Result taken here
            #2;
        end
    endtask

    task automatic cmd_without_response();
        logic [31:0] arg;
        open_test("no_response");
        arg = $random(seed);
        program_card(1'b0, 8'd2, 48'd0, 1'b0, 1'b0);
        check_flag("cmd_ready after reset", 1'b1, cmd_ready);
        check_flag("cmd_o idle level", 1'b1, cmd_o);
        issue_cmd(6'd0, arg, RESP_NONE, 1'b0, 1'b0);
        wait_result();
        check_flag("frame start bit", 1'b0, frm_start);
        check_flag("frame direction", 1'b1, frm_dir);
        check_field6("frame index", 6'd0, frm_index);
        check_field32("frame argument", arg, frm_arg);
        check_flag("frame crc7", 1'b1, frm_crc_ok);
        check_flag("frame end bit", 1'b1, frm_end);
        check_resp("resp_data", 48'd0, got_data);
        check_errs(1'b0, 1'b0, 1'b0);
        close_test();
    endtask

    task automatic r1_with_good_crc();
        logic [31:0] status;
        open_test("r1_ok");
        status = $random(seed);
        program_card(1'b1, 8'd2, make_word(6'd13, status), 1'b1, 1'b0);
        issue_cmd(6'd13, $random(seed), RESP_SHORT, 1'b1, 1'b1);
        wait_result();
        check_resp("resp_data", sent_word, got_data);
        check_field6("r1 index", 6'd13, got_data.r1.index);
        check_field32("r1 status", status, got_data.r1.status);
        check_errs(1'b0, 1'b0, 1'b0);
        close_test();
    endtask

    task automatic corrupted_response_crc();
        open_test("crc_error");
        program_card(1'b1, 8'd4, make_word(6'd17, $random(seed)), 1'b1, 1'b1);
        issue_cmd(6'd17, $random(seed), RESP_SHORT, 1'b1, 1'b1);
        wait_result();
        check_errs(1'b0, 1'b1, 1'b0);
        issue_cmd(6'd17, $random(seed), RESP_SHORT, 1'b1, 1'b0);  // Bad crc again unchecked
        wait_result();
        check_errs(1'b0, 1'b0, 1'b0);
        check_resp("resp_data", sent_word, got_data);
        close_test();
    endtask

    task automatic index_mismatch_and_r3();
        logic [31:0] ocr;
        open_test("index_and_r3");
        program_card(1'b1, 8'd2, make_word(6'd18, $random(seed)), 1'b1, 1'b0);
        issue_cmd(6'd55, $random(seed), RESP_SHORT, 1'b1, 1'b1);
        wait_result();
        check_errs(1'b0, 1'b0, 1'b1);
        check_field6("r1 index", 6'd18, got_data.r1.index);
        ocr = $random(seed);
        program_card(1'b1, 8'd3, make_word(6'h3f, ocr), 1'b0, 1'b0);  // R3 keeps all ones
        issue_cmd(6'd41, $random(seed), RESP_SHORT_NOCRC, 1'b1, 1'b1);
        wait_result();
        check_errs(1'b0, 1'b0, 1'b0);
        check_field32("r3 ocr", ocr, got_data.r3.ocr);
        close_test();
    endtask

    task automatic silent_card_timeout();
        open_test("silent_card");
        program_card(1'b0, 8'd2, 48'd0, 1'b0, 1'b0);
        issue_cmd(6'd8, $random(seed), RESP_SHORT, 1'b1, 1'b1);
        wait_result();
        check_errs(1'b1, 1'b0, 1'b0);
        check_resp("resp_data", 48'd0, got_data);
        program_card(1'b1, 8'd6, make_word(6'd8, $random(seed)), 1'b1, 1'b0);
        issue_cmd(6'd8, $random(seed), RESP_SHORT, 1'b1, 1'b1);
        wait_result();
        check_errs(1'b0, 1'b0, 1'b0);
        check_resp("resp_data after timeout", sent_word, got_data);
        close_test();
    endtask

    task automatic held_result_back_pressure();
        logic [31:0] frames;
        open_test("back_pressure");
        resp_ready = 1'b0;
        program_card(1'b1, 8'd2, make_word(6'd55, $random(seed)), 1'b1, 1'b0);
        issue_cmd(6'd55, $random(seed), RESP_SHORT, 1'b1, 1'b1);
        wait_result();
        check_resp("resp_data", sent_word, got_data);
        program_card(1'b0, 8'd2, 48'd0, 1'b0, 1'b0);
        drive_request(6'd12, 32'h0000_0000, RESP_NONE, 1'b0, 1'b0);  // Pending request
        frames = frm_count;
        repeat (50) begin
            @(posedge clk);
            #2;
            check_flag("resp_valid held", 1'b1, resp_valid);
            check_resp("resp_data held", got_data, resp_data);
            check_flag("timeout_err held", got_tmo, timeout_err);
            check_flag("crc_err held", got_crc, crc_err);
            check_flag("index_err held", got_idx, index_err);
            check_flag("cmd_ready low", 1'b0, cmd_ready);
            check_flag("cmd_oe low", 1'b0, cmd_oe);
        end
        check_field32("frames while held", frames, frm_count);
        resp_ready = 1'b1;
        @(posedge clk);
        #2;
        wait_accept();
        wait_result();
        check_field32("frames after release", frames + 32'd1, frm_count);
        check_field6("pending index", 6'd12, frm_index);
        check_resp("resp_data", 48'd0, got_data);
        check_errs(1'b0, 1'b0, 1'b0);
        close_test();
    endtask

    initial begin
        rst_n          = 1'b0;
        cmd_valid      = 1'b0;
        cmd_index      = 6'd0;
        cmd_arg        = 32'd0;
        resp_type      = RESP_NONE;
        index_check_en = 1'b0;
        crc_check_en   = 1'b0;
        resp_ready     = 1'b1;
        passed         = 0;
        failed         = 0;
        program_card(1'b0, 8'd2, 48'd0, 1'b0, 1'b0);
        repeat (4) @(posedge clk);
        #2 rst_n = 1'b1;
        @(posedge clk);
        #2;
        cmd_without_response();
        r1_with_good_crc();
        corrupted_response_crc();
        index_mismatch_and_r3();
        silent_card_timeout();
        held_result_back_pressure();
        $display("Tests run %0d, passed %0d, failed %0d", passed + failed, passed, failed);
        if (failed == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        $display("Timeout, the tests did not finish within %0d clock cycles", MAX_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- tests/sd_card_responder.sv
`timescale 1ns/1ps

module sd_card_responder (
    input  logic        sd_clk,
    input  logic        cmd_o,
    input  logic        cmd_oe,
    output logic        cmd_i,
    input  logic        resp_en,      // 0 keeps the card silent
    input  logic [7:0]  resp_gap,     // SD clocks before the start bit
    input  logic [47:0] resp_word,
    input  logic        crc_fill,     // Put the real crc into bits 7..1
    input  logic        crc_corrupt,  // Flip the last crc bit
    output logic        frm_start,
    output logic        frm_dir,
    output logic [5:0]  frm_index,
    output logic [31:0] frm_arg,
    output logic        frm_crc_ok,
    output logic        frm_end,
    output logic [31:0] frm_count,
    output logic [47:0] sent_word
);
    logic [47:0] frame;
    logic [47:0] word;
    int          nbits;

    // CRC7 over x^7 + x^3 + 1 taken msb first
    function automatic logic [6:0] crc7_of(input logic [39:0] bits);
        logic [6:0] c;
        logic       fb;
        c = 7'd0;
        for (int i = 39; i >= 0; i--) begin
            fb = c[6] ^ bits[i];
            c  = {c[5:0], 1'b0};
            if (fb) begin
                c = c ^ 7'b000_1001;  // Taps x^3 and x^0
            end
        end
        return c;
    endfunction

    initial begin
        cmd_i     = 1'b1;
        frm_count = 32'd0;
        sent_word = 48'd0;
        forever begin
            nbits = 0;
            while (nbits < 48) begin
                @(posedge sd_clk);
                if (cmd_oe) begin  // Host bit is mid-period here
                    frame = {frame[46:0], cmd_o};
                    nbits = nbits + 1;
                end
            end
            {frm_start, frm_dir, frm_index, frm_arg} = frame[47:8];
            frm_crc_ok = (frame[7:1] == crc7_of(frame[47:8]));
            frm_end    = frame[0];
            frm_count  = frm_count + 32'd1;
            if (resp_en) begin
                word = resp_word;
                if (crc_fill) begin
                    word[7:1] = crc7_of(word[47:8]);
                end
                if (crc_corrupt) begin
                    word[1] = ~word[1];
                end
                sent_word = word;
                repeat (resp_gap) @(posedge sd_clk);
                for (int i = 47; i >= 0; i--) begin
                    @(posedge sd_clk);
                    #2 cmd_i = word[i];  // Half a bit before the host samples
                end
                @(posedge sd_clk);
                #2 cmd_i = 1'b1;
            end
        end
    end

endmodule

//--- src/sd_cmd_host.sv
`timescale 1ns/1ps

module sd_cmd_host #(
    parameter int CLK_DIV      = 4,
    parameter int RESP_TIMEOUT = 64
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cmd_valid,
    output logic                cmd_ready,
    input  logic [5:0]          cmd_index,
    input  logic [31:0]         cmd_arg,
    input  logic [1:0]          resp_type,
    input  logic                index_check_en,
    input  logic                crc_check_en,
    output logic                resp_valid,
    input  logic                resp_ready,
    output sd_cmd_pkg::resp48_u resp_data,
    output logic                timeout_err,
    output logic                crc_err,
    output logic                index_err,
    output logic                sd_clk,
    output logic                cmd_o,
    output logic                cmd_oe,
    input  logic                cmd_i
);
    logic        bit_stb;
    logic        tx_start;
    logic [5:0]  tx_index;
    logic [31:0] tx_arg;
    logic        tx_done;
    logic        rx_arm;
    logic        rx_started;
    logic        rx_done;
    logic        rx_crc_ok;
    logic [47:0] rx_word;

    sd_clk_div #(.CLK_DIV(CLK_DIV)) i_clk_div (
        .clk     (clk),
        .rst_n   (rst_n),
        .sd_clk  (sd_clk),
        .bit_stb (bit_stb)
    );

    sd_cmd_tx i_tx (
        .clk       (clk),
        .rst_n     (rst_n),
        .bit_stb   (bit_stb),
        .tx_start  (tx_start),
        .cmd_index (tx_index),
        .cmd_arg   (tx_arg),
        .cmd_o     (cmd_o),
        .cmd_oe    (cmd_oe),
        .tx_done   (tx_done)
    );

    sd_cmd_rx i_rx (
        .clk        (clk),
        .rst_n      (rst_n),
        .bit_stb    (bit_stb),
        .rx_arm     (rx_arm),
        .cmd_i      (cmd_i),
        .rx_started (rx_started),
        .rx_done    (rx_done),
        .rx_crc_ok  (rx_crc_ok),
        .rx_word    (rx_word)
    );

    cmd_path_ctrl #(.RESP_TIMEOUT(RESP_TIMEOUT)) i_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .cmd_valid      (cmd_valid),
        .cmd_ready      (cmd_ready),
        .cmd_index      (cmd_index),
        .cmd_arg        (cmd_arg),
        .resp_type      (resp_type),
        .index_check_en (index_check_en),
        .crc_check_en   (crc_check_en),
        .bit_stb        (bit_stb),
        .tx_start       (tx_start),
        .tx_index       (tx_index),
        .tx_arg         (tx_arg),
        .tx_done        (tx_done),
        .rx_arm         (rx_arm),
        .rx_started     (rx_started),
        .rx_done        (rx_done),
        .rx_crc_ok      (rx_crc_ok),
        .rx_word        (rx_word),
        .resp_valid     (resp_valid),
        .resp_ready     (resp_ready),
        .resp_data      (resp_data),
        .timeout_err    (timeout_err),
        .crc_err        (crc_err),
        .index_err      (index_err)
    );

endmodule

//--- src/cmd_path_ctrl.sv
`timescale 1ns/1ps

module cmd_path_ctrl #(
    parameter int RESP_TIMEOUT = 64
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cmd_valid,
    output logic                cmd_ready,
    input  logic [5:0]          cmd_index,
    input  logic [31:0]         cmd_arg,
    input  logic [1:0]          resp_type,
    input  logic                index_check_en,
    input  logic                crc_check_en,
    input  logic                bit_stb,
    output logic                tx_start,
    output logic [5:0]          tx_index,
    output logic [31:0]         tx_arg,
    input  logic                tx_done,
    output logic                rx_arm,
    input  logic                rx_started,
    input  logic                rx_done,
    input  logic                rx_crc_ok,
    input  logic [47:0]         rx_word,
    output logic                resp_valid,
    input  logic                resp_ready,
    output sd_cmd_pkg::resp48_u resp_data,
    output logic                timeout_err,
    output logic                crc_err,
    output logic                index_err
);
    import sd_cmd_pkg::*;

    localparam logic [2:0] IDLE      = 3'd0;
    localparam logic [2:0] SEND      = 3'd1;
    localparam logic [2:0] WAIT_RESP = 3'd2;
    localparam logic [2:0] RECV      = 3'd3;
    localparam logic [2:0] REPORT    = 3'd4;

    localparam int TW = $clog2(RESP_TIMEOUT + 1);

    logic [2:0]    state;
    logic [5:0]    idx_q;
    logic [31:0]   arg_q;
    logic [1:0]    type_q;
    logic          idx_chk_q;
    logic          crc_chk_q;
    logic [TW-1:0] tmo_cnt;   // Bit periods waited
    logic          accept;
    logic          tmo_hit;
    resp48_u       rx_resp;

    assign accept     = cmd_valid && cmd_ready;
    assign cmd_ready  = (state == IDLE);
    assign resp_valid = (state == REPORT);
    assign rx_arm     = (state == WAIT_RESP) || (state == RECV);
    assign tx_index   = idx_q;
    assign tx_arg     = arg_q;
    assign rx_resp    = rx_word;
    assign tmo_hit    = bit_stb && (tmo_cnt == TW'(RESP_TIMEOUT - 1));

    always_ff @(posedge clk) begin
        if (accept) begin
            idx_q     <= cmd_index;
            arg_q     <= cmd_arg;
            type_q    <= resp_type;
            idx_chk_q <= index_check_en;
            crc_chk_q <= crc_check_en;
        end
    end

    // Result word is zero unless a response was really received
    always_ff @(posedge clk) begin
        if ((state == SEND && tx_done) ||
            (state == WAIT_RESP && !rx_started && tmo_hit)) begin
            resp_data <= '0;
        end else if (state == RECV && rx_done) begin
            resp_data <= rx_resp;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= IDLE;
            tx_start    <= 1'b0;
            tmo_cnt     <= '0;
            timeout_err <= 1'b0;
            crc_err     <= 1'b0;
            index_err   <= 1'b0;
        end else begin
            tx_start <= accept;
            case (state)
                IDLE: begin
                    if (accept) begin
                        state       <= SEND;
                        timeout_err <= 1'b0;
                        crc_err     <= 1'b0;
                        index_err   <= 1'b0;
                    end
                end
                SEND: begin
                    if (tx_done) begin
                        tmo_cnt <= '0;
                        state   <= (type_q == RESP_NONE) ? REPORT : WAIT_RESP;
                    end
                end
                WAIT_RESP: begin
                    if (rx_started) begin
                        state <= RECV;
                    end else if (tmo_hit) begin
                        state       <= REPORT;
                        timeout_err <= 1'b1;
                    end else if (bit_stb) begin
                        tmo_cnt <= tmo_cnt + 1'b1;
                    end
                end
                RECV: begin
                    if (rx_done) begin
                        state     <= REPORT;
                        crc_err   <= crc_chk_q && (type_q != RESP_SHORT_NOCRC) && !rx_crc_ok;
                        index_err <= idx_chk_q && (type_q == RESP_SHORT) &&
                                     (rx_resp.r1.index != idx_q);
                    end
                end
                REPORT: begin
                    if (resp_ready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Long responses are not handled by this path
    a_no_r2: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> (resp_type != 2'd2));

    a_result_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (resp_valid && !resp_ready) |=> resp_valid && $stable(resp_data) &&
            $stable({timeout_err, crc_err, index_err}));

endmodule

//--- src/sd_cmd_rx.sv
`timescale 1ns/1ps

module sd_cmd_rx (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        bit_stb,
    input  logic        rx_arm,
    input  logic        cmd_i,
    output logic        rx_started,
    output logic        rx_done,
    output logic        rx_crc_ok,
    output logic [47:0] rx_word
);
    import sd_cmd_pkg::*;

    localparam logic [5:0] CRC_END = 6'(RESP_LEN - 8);  // Bits 47..8 feed the crc
    localparam logic [5:0] LAST    = 6'(RESP_LEN - 1);

    logic        recv;
    logic [5:0]  cnt;    // Bits taken so far
    logic [47:0] sreg;
    logic        start;
    logic        take;
    logic [6:0]  crc;

    assign start = rx_arm && !recv && bit_stb && !cmd_i;  // Start bit seen
    assign take  = rx_arm && recv && bit_stb;

    sd_crc7 i_crc (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (!recv && !start),
        .shift (start || (take && (cnt < CRC_END))),
        .din   (cmd_i),
        .crc   (crc)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            recv      <= 1'b0;
            cnt       <= 6'd0;
            rx_done   <= 1'b0;
            rx_crc_ok <= 1'b0;
        end else begin
            rx_done <= 1'b0;
            if (!rx_arm) begin           // Abort
                recv <= 1'b0;
                cnt  <= 6'd0;
            end else if (start) begin
                recv <= 1'b1;
                cnt  <= 6'd1;
            end else if (take) begin
                if (cnt == LAST) begin
                    recv      <= 1'b0;
                    cnt       <= 6'd0;
                    rx_done   <= 1'b1;
                    rx_crc_ok <= (crc == sreg[6:0]);  // Received bits 7..1
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start || take) begin
            sreg <= {sreg[46:0], cmd_i};
        end
    end

    assign rx_word    = sreg;
    assign rx_started = recv;

endmodule

//--- src/sd_cmd_tx.sv
`timescale 1ns/1ps

module sd_cmd_tx (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        bit_stb,
    input  logic        tx_start,
    input  logic [5:0]  cmd_index,
    input  logic [31:0] cmd_arg,
    output logic        cmd_o,
    output logic        cmd_oe,
    output logic        tx_done
);
    import sd_cmd_pkg::*;

    localparam logic [5:0] CRC_POS = 6'(CMD_FRAME_LEN - 8);  // First crc bit
    localparam logic [5:0] LAST    = 6'(CMD_FRAME_LEN);      // Release slot

    logic        busy;
    logic [5:0]  cnt;
    logic [39:0] sreg;
    logic [39:0] head;
    logic        go;
    logic [6:0]  crc;

    // Frame head comes straight from the inputs on the very first bit
    assign head = busy ? sreg : {1'b0, 1'b1, cmd_index, cmd_arg};
    assign go   = bit_stb && (busy || tx_start);

    sd_crc7 i_crc (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (!busy && !tx_start),
        .shift (go && (cnt < CRC_POS)),
        .din   (head[39]),
        .crc   (crc)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            cnt     <= 6'd0;
            cmd_o   <= 1'b1;
            cmd_oe  <= 1'b0;
            tx_done <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            if (go) begin
                if (cnt == LAST) begin   // End bit period is over
                    busy    <= 1'b0;
                    cnt     <= 6'd0;
                    cmd_o   <= 1'b1;
                    cmd_oe  <= 1'b0;
                    tx_done <= 1'b1;
                end else begin
                    busy   <= 1'b1;
                    cnt    <= cnt + 1'b1;
                    cmd_oe <= 1'b1;
                    cmd_o  <= (cnt == CRC_POS) ? crc[6] : head[39];
                end
            end else if (tx_start) begin
                busy <= 1'b1;            // Wait for the next strobe
            end
        end
    end

    // CRC and end bit are spliced in behind the payload
    always_ff @(posedge clk) begin
        if (go) begin
            sreg <= (cnt == CRC_POS) ? {crc[5:0], 1'b1, 33'd0} : {head[38:0], 1'b0};
        end else if (tx_start) begin
            sreg <= head;
        end
    end

    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        tx_start |-> !busy);

endmodule

//--- src/sd_clk_div.sv
`timescale 1ns/1ps

module sd_clk_div #(
    parameter int CLK_DIV = 4
) (
    input  logic clk,
    input  logic rst_n,
    output logic sd_clk,
    output logic bit_stb
);
    localparam int HALF = CLK_DIV / 2;
    localparam int CW   = (HALF > 1) ? $clog2(HALF) : 1;

    logic [CW-1:0] cnt;
    logic          edge_now;

    assign edge_now = (cnt == CW'(HALF - 1));  // sd_clk toggles on this cycle

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt    <= '0;
            sd_clk <= 1'b0;
        end else if (edge_now) begin
            cnt    <= '0;
            sd_clk <= ~sd_clk;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // Strobe sits on the cycle whose closing edge drops sd_clk,
    // so the bit boundary and the strobe share one clk edge
    assign bit_stb = edge_now && sd_clk;

    a_stb_single: assert property (@(posedge clk) disable iff (!rst_n)
        bit_stb |=> !bit_stb);

endmodule

//--- src/sd_crc7.sv
`timescale 1ns/1ps

module sd_crc7 (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       clear,
    input  logic       shift,
    input  logic       din,
    output logic [6:0] crc
);
    import sd_cmd_pkg::*;

    logic fb;

    assign fb = crc[6] ^ din;  // Feedback of the serial LFSR

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc <= 7'd0;
        end else if (clear) begin
            crc <= 7'd0;  // Clear wins over shift
        end else if (shift) begin
            crc <= {crc[5:0], 1'b0} ^ ({7{fb}} & CRC7_POLY);
        end
    end

endmodule

//--- src/sd_cmd_pkg.sv
package sd_cmd_pkg;

    localparam int CMD_FRAME_LEN = 48;         // Start, dir, index, arg, crc, end
    localparam int RESP_LEN      = 48;         // Short response length

    localparam logic [6:0] CRC7_POLY = 7'h09;  // x^7 + x^3 + 1

    // Response type codes as seen on the request port
    localparam logic [1:0] RESP_NONE        = 2'd0;
    localparam logic [1:0] RESP_SHORT       = 2'd1;  // R1, R6, R7
    localparam logic [1:0] RESP_SHORT_NOCRC = 2'd3;  // R3 without crc or index check

    // One 48-bit response word read either as R1 or as R3
    typedef union packed {
        struct packed {
            logic        start;
            logic        dir;
            logic [5:0]  index;
            logic [31:0] status;   // Card status
            logic [6:0]  crc;
            logic        stop;
        } r1;
        struct packed {
            logic        start;
            logic        dir;
            logic [5:0]  rsvd_hi;  // All ones on the wire
            logic [31:0] ocr;
            logic [6:0]  rsvd_lo;  // All ones in place of crc
            logic        stop;
        } r3;
    } resp48_u;

endpackage
